// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_rv_exec_top
FILELIST = filelist.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
PASS_TEXT = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@output="$$(./$(BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+source
source/rv_exec_pkg.sv
source/rv_alu.sv
source/rv_multiplier.sv
source/rv_divider.sv
source/rv_csr_file.sv
source/rv_execute.sv
source/rv_exec_top.sv
testbench/tb_rv_exec_top.sv

// ==== source/rv_alu.sv ====
`include "rv_exec_defines.svh"

module rv_alu import rv_exec_pkg::*; (
	input alu_op_t i_op,
	input logic [`RV_XLEN-1:0] i_op1,
	input logic [`RV_XLEN-1:0] i_op2,
	output logic [`RV_XLEN-1:0] o_result,
	output logic o_compare
);

	logic [4:0] shift_amount;
	logic equal;
	logic less_signed;
	logic less_unsigned;

	assign shift_amount = i_op2[4:0];
	assign equal = (i_op1 == i_op2);
	assign less_signed = ($signed(i_op1) < $signed(i_op2));
	assign less_unsigned = (i_op1 < i_op2);

	// Compare bit
	always_comb begin
		case (i_op)
			ALU_EQ: o_compare = equal;
			ALU_NE: o_compare = !equal;
			ALU_LT: o_compare = less_signed;
			ALU_LTU: o_compare = less_unsigned;
			ALU_GE: o_compare = !less_signed;
			ALU_GEU: o_compare = !less_unsigned;
			default: o_compare = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_op1 + i_op2;
			ALU_SUB: o_result = i_op1 - i_op2;
			ALU_SLL: o_result = i_op1 << shift_amount;
			ALU_SRL: o_result = i_op1 >> shift_amount;
			ALU_SRA: o_result = $unsigned($signed(i_op1) >>> shift_amount);
			ALU_AND: o_result = i_op1 & i_op2;
			ALU_OR: o_result = i_op1 | i_op2;
			ALU_XOR: o_result = i_op1 ^ i_op2;
			// Compare ops give the bit zero extended
			default: o_result = {{(`RV_XLEN-1){1'b0}}, o_compare};
		endcase
	end

endmodule

// ==== source/rv_csr_file.sv ====
`include "rv_exec_defines.svh"

module rv_csr_file (
	input logic i_clock,
	input logic i_reset,
	csr_bus_if.csr bus
);

	logic [`RV_XLEN-1:0] mscratch;
	logic [`RV_XLEN-1:0] mtvec;
	logic [`RV_XLEN-1:0] mepc;
	logic [`RV_XLEN-1:0] mcycle;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mscratch <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcycle <= '0;
		end else begin
			mcycle <= mcycle + 1'b1;
			if (bus.write) begin
				// mcycle and unknown addresses drop the write
				case (bus.index)
					`RV_CSR_MSCRATCH: mscratch <= bus.wdata;
					`RV_CSR_MTVEC: mtvec <= bus.wdata;
					`RV_CSR_MEPC: mepc <= bus.wdata;
					default: ;
				endcase
			end
		end
	end

	// ==============================
	// Read port
	always_comb begin
		case (bus.index)
			`RV_CSR_MSCRATCH: bus.rdata = mscratch;
			`RV_CSR_MTVEC: bus.rdata = mtvec;
			`RV_CSR_MEPC: bus.rdata = mepc;
			`RV_CSR_MCYCLE: bus.rdata = mcycle;
			default: bus.rdata = '0;
		endcase
	end

	assign bus.mepc = mepc;

endmodule

// ==== source/rv_divider.sv ====
`include "rv_exec_defines.svh"

module rv_divider (
	input logic i_clock,
	input logic i_reset,
	muldiv_if.div bus
);

	logic running;
	logic done;
	logic [5:0] count;
	logic [`RV_XLEN-1:0] dividend;
	logic [`RV_XLEN-1:0] divisor;
	logic [`RV_XLEN-1:0] quotient;
	logic [`RV_XLEN-1:0] remainder;
	logic negate_quotient;
	logic negate_remainder;
	logic divide_by_zero;
	logic [`RV_XLEN:0] shifted;
	logic fits;
	logic [`RV_XLEN-1:0] next_quotient;
	logic [`RV_XLEN-1:0] next_remainder;
	logic [`RV_XLEN-1:0] quotient_out;
	logic [`RV_XLEN-1:0] remainder_out;

	// One restoring step, dividend bits shift out of the quotient register
	assign shifted = {remainder, quotient[`RV_XLEN-1]};
	assign fits = (shifted >= {1'b0, divisor});
	assign next_remainder = fits ? (shifted[`RV_XLEN-1:0] - divisor) : shifted[`RV_XLEN-1:0];
	assign next_quotient = {quotient[`RV_XLEN-2:0], fits};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running <= 1'b0;
			done <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (bus.div_start) begin
				running <= 1'b1;
				count <= 6'(`RV_XLEN);
			end else if (running) begin
				count <= count - 6'd1;
				if (count == 6'd1) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (bus.div_start) begin
			dividend <= bus.op1;
			remainder <= '0;
			quotient <= (bus.is_signed && bus.op1[`RV_XLEN-1]) ? -bus.op1 : bus.op1;
			divisor <= (bus.is_signed && bus.op2[`RV_XLEN-1]) ? -bus.op2 : bus.op2;
			negate_quotient <= bus.is_signed & (bus.op1[`RV_XLEN-1] ^ bus.op2[`RV_XLEN-1]);
			negate_remainder <= bus.is_signed & bus.op1[`RV_XLEN-1];
			divide_by_zero <= (bus.op2 == '0);
		end else if (running) begin
			quotient <= next_quotient;
			remainder <= next_remainder;
			if (count == 6'd1) begin
				// Signed overflow already yields the dividend and zero here
				if (divide_by_zero) begin
					quotient_out <= '1;
					remainder_out <= dividend;
				end else begin
					quotient_out <= negate_quotient ? -next_quotient : next_quotient;
					remainder_out <= negate_remainder ? -next_remainder : next_remainder;
				end
			end
		end
	end

	assign bus.div_done = done;
	assign bus.div_quotient = quotient_out;
	assign bus.div_remainder = remainder_out;

endmodule

// ==== source/rv_exec_defines.svh ====
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// Datapath widths
`define RV_XLEN 32
`define RV_TAG_WIDTH 4

// ==============================
// Machine CSR addresses
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MTVEC 12'h305
`define RV_CSR_MEPC 12'h341
`define RV_CSR_MCYCLE 12'hB00

`endif

// ==== source/rv_exec_pkg.sv ====
`include "rv_exec_defines.svh"

package rv_exec_pkg;

	typedef enum logic [2:0] {
		CLASS_ARITH,
		CLASS_COMPARE,
		CLASS_JUMP,
		CLASS_BRANCH,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_COMPLEX,
		CLASS_INVALID
	} exec_class_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_LTU,
		ALU_GE,
		ALU_GEU
	} alu_op_t;

	typedef enum logic [2:0] {
		SEL_ZERO,
		SEL_RS1,
		SEL_RS2,
		SEL_PC,
		SEL_IMM
	} operand_sel_t;

	// Codes above OP_MRET are unknown and fault
	typedef enum logic [3:0] {
		OP_MUL,
		OP_MULH,
		OP_MULHU,
		OP_DIV,
		OP_DIVU,
		OP_REM,
		OP_REMU,
		OP_CSRRW,
		OP_CSRRS,
		OP_CSRRC,
		OP_MRET
	} complex_op_t;

endpackage

// ==============================
// CSR access between execute and the CSR file
interface csr_bus_if;
	logic [11:0] index;
	logic write;
	logic [`RV_XLEN-1:0] wdata;
	logic [`RV_XLEN-1:0] rdata;
	logic [`RV_XLEN-1:0] mepc;

	modport execute (output index, write, wdata, input rdata, mepc);
	modport csr (input index, write, wdata, output rdata, mepc);
endinterface

// ==============================
// Start/done link to the multiply and divide units
interface muldiv_if;
	logic mul_start;
	logic div_start;
	logic is_signed;
	logic high;
	logic [`RV_XLEN-1:0] op1;
	logic [`RV_XLEN-1:0] op2;
	logic mul_done;
	logic [`RV_XLEN-1:0] mul_result;
	logic div_done;
	logic [`RV_XLEN-1:0] div_quotient;
	logic [`RV_XLEN-1:0] div_remainder;

	modport execute (
		output mul_start, div_start, is_signed, high, op1, op2,
		input mul_done, mul_result, div_done, div_quotient, div_remainder
	);
	modport mul (
		input mul_start, is_signed, high, op1, op2,
		output mul_done, mul_result
	);
	modport div (
		input div_start, is_signed, op1, op2,
		output div_done, div_quotient, div_remainder
	);
endinterface

// ==== source/rv_exec_top.sv ====
`include "rv_exec_defines.svh"

module rv_exec_top import rv_exec_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_memory_busy,
	input logic i_decode_valid,
	output logic o_busy,

	input logic [`RV_TAG_WIDTH-1:0] i_tag,
	input logic [`RV_XLEN-1:0] i_pc,
	input logic [`RV_XLEN-1:0] i_rs1,
	input logic [`RV_XLEN-1:0] i_rs2,
	input logic [`RV_XLEN-1:0] i_imm,
	input logic [4:0] i_rd_index,
	input exec_class_t i_class,
	input alu_op_t i_alu_op,
	input operand_sel_t i_operand1_sel,
	input operand_sel_t i_operand2_sel,
	input complex_op_t i_complex_op,
	input logic [2:0] i_mem_width,
	input logic i_mem_signed,

	output logic o_valid,
	output logic [`RV_TAG_WIDTH-1:0] o_tag,
	output logic [4:0] o_rd_index,
	output logic [`RV_XLEN-1:0] o_rd,
	output logic o_jump,
	output logic [`RV_XLEN-1:0] o_jump_pc,
	output logic o_fault,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [2:0] o_mem_width,
	output logic o_mem_signed,
	output logic [`RV_XLEN-1:0] o_mem_address
);

	csr_bus_if csr_bus ();
	muldiv_if muldiv_bus ();

	rv_execute execute_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_memory_busy(i_memory_busy),
		.i_decode_valid(i_decode_valid),
		.o_busy(o_busy),
		.i_tag(i_tag),
		.i_pc(i_pc),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_imm(i_imm),
		.i_rd_index(i_rd_index),
		.i_class(i_class),
		.i_alu_op(i_alu_op),
		.i_operand1_sel(i_operand1_sel),
		.i_operand2_sel(i_operand2_sel),
		.i_complex_op(i_complex_op),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.o_valid(o_valid),
		.o_tag(o_tag),
		.o_rd_index(o_rd_index),
		.o_rd(o_rd),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_mem_width(o_mem_width),
		.o_mem_signed(o_mem_signed),
		.o_mem_address(o_mem_address),
		.csr(csr_bus.execute),
		.muldiv(muldiv_bus.execute)
	);

	rv_csr_file csr_file_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(csr_bus.csr)
	);

	rv_multiplier multiplier_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(muldiv_bus.mul)
	);

	rv_divider divider_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(muldiv_bus.div)
	);

endmodule

// ==== source/rv_execute.sv ====
`include "rv_exec_defines.svh"

module rv_execute import rv_exec_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Control
	input logic i_memory_busy,
	input logic i_decode_valid,
	output logic o_busy,

	// Decoded instruction
	input logic [`RV_TAG_WIDTH-1:0] i_tag,
	input logic [`RV_XLEN-1:0] i_pc,
	input logic [`RV_XLEN-1:0] i_rs1,
	input logic [`RV_XLEN-1:0] i_rs2,
	input logic [`RV_XLEN-1:0] i_imm,
	input logic [4:0] i_rd_index,
	input exec_class_t i_class,
	input alu_op_t i_alu_op,
	input operand_sel_t i_operand1_sel,
	input operand_sel_t i_operand2_sel,
	input complex_op_t i_complex_op,
	input logic [2:0] i_mem_width,
	input logic i_mem_signed,

	// Result
	output logic o_valid,
	output logic [`RV_TAG_WIDTH-1:0] o_tag,
	output logic [4:0] o_rd_index,
	output logic [`RV_XLEN-1:0] o_rd,
	output logic o_jump,
	output logic [`RV_XLEN-1:0] o_jump_pc,
	output logic o_fault,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [2:0] o_mem_width,
	output logic o_mem_signed,
	output logic [`RV_XLEN-1:0] o_mem_address,

	csr_bus_if.execute csr,
	muldiv_if.execute muldiv
);

	logic busy;
	logic accept;
	logic is_csr_op;
	logic [`RV_XLEN-1:0] operand1;
	logic [`RV_XLEN-1:0] operand2;
	logic [`RV_XLEN-1:0] alu_result;
	logic alu_compare;
	complex_op_t pending_op;
	logic [`RV_XLEN-1:0] pending_op1;
	logic [`RV_XLEN-1:0] pending_op2;
	logic pending_signed;
	logic pending_high;
	logic mul_start_q;
	logic div_start_q;

	function automatic logic [`RV_XLEN-1:0] select_operand(
		input operand_sel_t sel,
		input logic [`RV_XLEN-1:0] rs1,
		input logic [`RV_XLEN-1:0] rs2,
		input logic [`RV_XLEN-1:0] pc,
		input logic [`RV_XLEN-1:0] imm
	);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	assign o_busy = busy | i_memory_busy;
	assign accept = i_decode_valid & ~o_busy;

	// ==============================
	// ALU
	assign operand1 = select_operand(i_operand1_sel, i_rs1, i_rs2, i_pc, i_imm);
	assign operand2 = select_operand(i_operand2_sel, i_rs1, i_rs2, i_pc, i_imm);

	rv_alu alu_i (
		.i_op(i_alu_op),
		.i_op1(operand1),
		.i_op2(operand2),
		.o_result(alu_result),
		.o_compare(alu_compare)
	);

	// ==============================
	// CSR, read and write in the accept cycle
	assign is_csr_op = (i_class == CLASS_COMPLEX) &&
		(i_complex_op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC});
	assign csr.index = i_imm[11:0];
	assign csr.write = accept & is_csr_op;

	always_comb begin
		case (i_complex_op)
			OP_CSRRS: csr.wdata = csr.rdata | i_rs1;
			OP_CSRRC: csr.wdata = csr.rdata & ~i_rs1;
			default: csr.wdata = i_rs1;
		endcase
	end

	// Mul/div operands come from the latched copies
	assign muldiv.mul_start = mul_start_q;
	assign muldiv.div_start = div_start_q;
	assign muldiv.is_signed = pending_signed;
	assign muldiv.high = pending_high;
	assign muldiv.op1 = pending_op1;
	assign muldiv.op2 = pending_op2;

	// ==============================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			o_valid <= 1'b0;
			o_jump <= 1'b0;
			o_fault <= 1'b0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			mul_start_q <= 1'b0;
			div_start_q <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			mul_start_q <= 1'b0;
			div_start_q <= 1'b0;

			if (accept) begin
				o_valid <= 1'b1;
				o_jump <= 1'b0;
				o_tag <= i_tag;
				o_rd_index <= i_rd_index;
				o_mem_read <= (i_class == CLASS_LOAD);
				o_mem_write <= (i_class == CLASS_STORE);
				o_mem_width <= i_mem_width;
				o_mem_signed <= i_mem_signed;
				o_mem_address <= alu_result;

				case (i_class)
					CLASS_ARITH: o_rd <= alu_result;
					CLASS_COMPARE: o_rd <= {{(`RV_XLEN-1){1'b0}}, alu_compare};
					CLASS_JUMP: begin
						o_rd <= i_pc + 32'd4;
						o_jump <= 1'b1;
						o_jump_pc <= alu_result;
					end
					CLASS_BRANCH: begin
						o_jump <= 1'b1;
						o_jump_pc <= alu_compare ? (i_pc + i_imm) : (i_pc + 32'd4);
					end
					CLASS_LOAD: ;
					CLASS_STORE: o_rd <= i_rs2;
					CLASS_COMPLEX: begin
						pending_op <= i_complex_op;
						pending_op1 <= i_rs1;
						pending_op2 <= i_rs2;
						pending_signed <= (i_complex_op inside {OP_MULH, OP_DIV, OP_REM});
						pending_high <= (i_complex_op inside {OP_MULH, OP_MULHU});
						case (i_complex_op)
							OP_MUL, OP_MULH, OP_MULHU: begin
								busy <= 1'b1;
								o_valid <= 1'b0;
								mul_start_q <= 1'b1;
							end
							OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
								busy <= 1'b1;
								o_valid <= 1'b0;
								div_start_q <= 1'b1;
							end
							OP_CSRRW, OP_CSRRS, OP_CSRRC: o_rd <= csr.rdata;
							OP_MRET: begin
								o_jump <= 1'b1;
								o_jump_pc <= csr.mepc;
							end
							default: o_fault <= 1'b1;
						endcase
					end
					default: o_fault <= 1'b1;
				endcase
			end else if (busy && (muldiv.mul_done || muldiv.div_done)) begin
				busy <= 1'b0;
				o_valid <= 1'b1;
				if (muldiv.mul_done) begin
					o_rd <= muldiv.mul_result;
				end else if (pending_op inside {OP_REM, OP_REMU}) begin
					o_rd <= muldiv.div_remainder;
				end else begin
					o_rd <= muldiv.div_quotient;
				end
			end
		end
	end

endmodule

// ==== source/rv_multiplier.sv ====
`include "rv_exec_defines.svh"

module rv_multiplier (
	input logic i_clock,
	input logic i_reset,
	muldiv_if.mul bus
);

	logic stage1_valid;
	logic done;
	logic high_select;
	logic signed [`RV_XLEN:0] op1_ext;
	logic signed [`RV_XLEN:0] op2_ext;
	logic signed [2*`RV_XLEN+1:0] product;
	logic [`RV_XLEN-1:0] result;

	// One extra bit turns unsigned operands into positive signed ones
	assign product = op1_ext * op2_ext;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			stage1_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			stage1_valid <= bus.mul_start;
			done <= stage1_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (bus.mul_start) begin
			op1_ext <= {bus.is_signed & bus.op1[`RV_XLEN-1], bus.op1};
			op2_ext <= {bus.is_signed & bus.op2[`RV_XLEN-1], bus.op2};
			high_select <= bus.high;
		end
		if (stage1_valid) begin
			result <= high_select ? product[2*`RV_XLEN-1:`RV_XLEN] : product[`RV_XLEN-1:0];
		end
	end

	assign bus.mul_done = done;
	assign bus.mul_result = result;

endmodule

// ==== testbench/tb_rv_exec_top.sv ====
`include "rv_exec_defines.svh"

module tb_rv_exec_top import rv_exec_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// About 200 instructions of at most 35 cycles, plus margin
	localparam int TIMEOUT_CYCLES = 200 * 35 + 3000;

	typedef struct {
		logic [`RV_TAG_WIDTH-1:0] tag;
		logic [4:0] rd_index;
		logic check_rd;
		logic [`RV_XLEN-1:0] rd;
		logic jump;
		logic [`RV_XLEN-1:0] jump_pc;
		logic mem_read;
		logic mem_write;
		logic check_mem;
		logic [`RV_XLEN-1:0] mem_address;
		logic [2:0] mem_width;
		logic mem_signed;
		logic fault;
		logic long_op;
		int accept_cycle;
		int due_cycle;
	} expected_t;

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_memory_busy;
	logic i_decode_valid;
	logic o_busy;
	logic [`RV_TAG_WIDTH-1:0] i_tag;
	logic [`RV_XLEN-1:0] i_pc;
	logic [`RV_XLEN-1:0] i_rs1;
	logic [`RV_XLEN-1:0] i_rs2;
	logic [`RV_XLEN-1:0] i_imm;
	logic [4:0] i_rd_index;
	exec_class_t i_class;
	alu_op_t i_alu_op;
	operand_sel_t i_operand1_sel;
	operand_sel_t i_operand2_sel;
	complex_op_t i_complex_op;
	logic [2:0] i_mem_width;
	logic i_mem_signed;
	logic o_valid;
	logic [`RV_TAG_WIDTH-1:0] o_tag;
	logic [4:0] o_rd_index;
	logic [`RV_XLEN-1:0] o_rd;
	logic o_jump;
	logic [`RV_XLEN-1:0] o_jump_pc;
	logic o_fault;
	logic o_mem_read;
	logic o_mem_write;
	logic [2:0] o_mem_width;
	logic o_mem_signed;
	logic [`RV_XLEN-1:0] o_mem_address;

	expected_t expected[$];
	int cycle = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	logic [31:0] rng_state = 32'd28641;
	logic [`RV_TAG_WIDTH-1:0] tag_counter = '0;
	logic [31:0] model_mscratch;
	logic [31:0] model_mtvec;
	logic [31:0] model_mepc;
	logic [31:0] model_mcycle;
	logic model_fault;
	logic [11:0] csr_list [3] = '{`RV_CSR_MSCRATCH, `RV_CSR_MTVEC, `RV_CSR_MEPC};

	rv_exec_top dut_i (.*);

	always #4 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Model of the free running cycle counter
	always @(posedge i_clock) begin
		if (i_reset) begin
			model_mcycle <= '0;
		end else begin
			model_mcycle <= model_mcycle + 32'd1;
		end
	end

	function automatic logic [31:0] random_word();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// ==============================
	// Reference model
	function automatic logic [31:0] pick_operand(input operand_sel_t sel, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] pc, input logic [31:0] imm);
		if (sel == SEL_RS1) return rs1;
		if (sel == SEL_RS2) return rs2;
		if (sel == SEL_PC) return pc;
		if (sel == SEL_IMM) return imm;
		return 32'd0;
	endfunction

	function automatic logic compare_model(input alu_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		case (op)
			ALU_EQ: return a == b;
			ALU_NE: return a != b;
			ALU_LT: return $signed(a) < $signed(b);
			ALU_LTU: return a < b;
			ALU_GE: return $signed(a) >= $signed(b);
			ALU_GEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] alu_model(input alu_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		int unsigned amount;
		amount = b % 32;
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a + ~b + 32'd1;
			ALU_SLL: return a << amount;
			ALU_SRL: return a >> amount;
			ALU_SRA: return $signed(a) >>> amount;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			default: return {31'd0, compare_model(op, a, b)};
		endcase
	endfunction

	function automatic logic [31:0] muldiv_model(input complex_op_t op, input logic [31:0] a,
			input logic [31:0] b);
		logic [63:0] product;
		logic [31:0] quotient;
		logic [31:0] remainder;
		logic is_signed;
		is_signed = (op == OP_DIV) || (op == OP_REM);
		if (op == OP_MUL) return a * b;
		if (op == OP_MULH) begin
			product = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			return product[63:32];
		end
		if (op == OP_MULHU) begin
			product = {32'd0, a} * {32'd0, b};
			return product[63:32];
		end
		if (b == 32'd0) begin
			quotient = '1;
			remainder = a;
		end else if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
			quotient = a;
			remainder = '0;
		end else if (is_signed) begin
			quotient = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b);
		end else begin
			quotient = a / b;
			remainder = a % b;
		end
		return (op == OP_REM || op == OP_REMU) ? remainder : quotient;
	endfunction

	function automatic logic [31:0] csr_read_model(input logic [11:0] index);
		case (index)
			`RV_CSR_MSCRATCH: return model_mscratch;
			`RV_CSR_MTVEC: return model_mtvec;
			`RV_CSR_MEPC: return model_mepc;
			`RV_CSR_MCYCLE: return model_mcycle;
			default: return '0;
		endcase
	endfunction

	// ==============================
	// Stimulus driven 1 ns after a rising edge
	task automatic issue(input exec_class_t cls, input alu_op_t aop, input operand_sel_t sel1,
			input operand_sel_t sel2, input complex_op_t cop, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] imm);
		expected_t e;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] extra;
		logic [31:0] old_csr;
		logic [31:0] new_csr;
		int latency;
		while (o_busy) begin
			@(posedge i_clock);
			#1;
		end
		pc = random_word() & 32'hffff_fffc;
		extra = random_word();
		a = pick_operand(sel1, rs1, rs2, pc, imm);
		b = pick_operand(sel2, rs1, rs2, pc, imm);
		e = '{default: '0};
		e.tag = tag_counter;
		e.rd_index = extra[4:0];
		e.mem_width = extra[7:5];
		e.mem_signed = extra[8];
		tag_counter = tag_counter + 1'b1;
		latency = 0;
		if (cls == CLASS_INVALID) begin
			model_fault = 1'b1;
		end
		e.fault = model_fault;
		case (cls)
			CLASS_ARITH, CLASS_COMPARE: begin
				e.check_rd = 1'b1;
				if (cls == CLASS_ARITH) e.rd = alu_model(aop, a, b);
				else e.rd = {31'd0, compare_model(aop, a, b)};
			end
			CLASS_JUMP: begin
				e.check_rd = 1'b1;
				e.rd = pc + 32'd4;
				e.jump = 1'b1;
				e.jump_pc = alu_model(aop, a, b);
			end
			CLASS_BRANCH: begin
				e.jump = 1'b1;
				e.jump_pc = compare_model(aop, a, b) ? pc + imm : pc + 32'd4;
			end
			CLASS_LOAD, CLASS_STORE: begin
				e.check_mem = 1'b1;
				e.mem_address = alu_model(aop, a, b);
				e.mem_read = (cls == CLASS_LOAD);
				e.mem_write = (cls == CLASS_STORE);
				e.check_rd = (cls == CLASS_STORE);
				e.rd = rs2;
			end
			CLASS_COMPLEX: begin
				if (cop inside {OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU}) begin
					latency = (cop inside {OP_MUL, OP_MULH, OP_MULHU}) ? 3 : 34;
					e.long_op = 1'b1;
					e.check_rd = 1'b1;
					e.rd = muldiv_model(cop, rs1, rs2);
				end else if (cop inside {OP_CSRRW, OP_CSRRS, OP_CSRRC}) begin
					old_csr = csr_read_model(imm[11:0]);
					if (cop == OP_CSRRW) new_csr = rs1;
					else if (cop == OP_CSRRS) new_csr = old_csr | rs1;
					else new_csr = old_csr & ~rs1;
					case (imm[11:0])
						`RV_CSR_MSCRATCH: model_mscratch = new_csr;
						`RV_CSR_MTVEC: model_mtvec = new_csr;
						`RV_CSR_MEPC: model_mepc = new_csr;
						default: ;
					endcase
					e.check_rd = 1'b1;
					e.rd = old_csr;
				end else if (cop == OP_MRET) begin
					e.jump = 1'b1;
					e.jump_pc = model_mepc;
				end
			end
			default: ;
		endcase
		i_class = cls;
		i_alu_op = aop;
		i_operand1_sel = sel1;
		i_operand2_sel = sel2;
		i_complex_op = cop;
		i_rs1 = rs1;
		i_rs2 = rs2;
		i_imm = imm;
		i_pc = pc;
		i_tag = e.tag;
		i_rd_index = e.rd_index;
		i_mem_width = e.mem_width;
		i_mem_signed = e.mem_signed;
		i_decode_valid = 1'b1;
		e.accept_cycle = cycle + 1;
		e.due_cycle = cycle + 1 + latency;
		expected.push_back(e);
		@(posedge i_clock);
		#1;
		i_decode_valid = 1'b0;
	endtask

	task automatic drain();
		while (expected.size() != 0) @(negedge i_clock);
		@(posedge i_clock);
		#1;
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		repeat (4) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		model_mscratch = '0;
		model_mtvec = '0;
		model_mepc = '0;
		model_fault = 1'b0;
	endtask

	// Hold a load in front of a busy memory stage
	task automatic stall_memory(input int cycles);
		i_memory_busy = 1'b1;
		i_class = CLASS_LOAD;
		i_decode_valid = 1'b1;
		repeat (cycles) begin
			@(posedge i_clock);
			#1;
			assert (o_busy) else begin
				protocol_errors++;
				$display("o_busy is low while the memory stage is busy at %0t", $time);
			end
		end
		i_decode_valid = 1'b0;
		i_memory_busy = 1'b0;
	endtask

	// ==============================
	// Checking
	task automatic report_mismatch(input string field, input logic [31:0] got,
			input logic [31:0] want);
		value_errors++;
		$display("[ERROR] %0t ns: %s is %h, expected %h", $time, field, got, want);
	endtask

	task automatic compare_result(input expected_t e);
		assert (cycle == e.due_cycle) else report_mismatch("o_valid cycle", cycle, e.due_cycle);
		assert (o_tag == e.tag) else report_mismatch("o_tag", o_tag, e.tag);
		assert (o_rd_index == e.rd_index)
			else report_mismatch("o_rd_index", o_rd_index, e.rd_index);
		assert (o_jump == e.jump) else report_mismatch("o_jump", o_jump, e.jump);
		assert (o_fault == e.fault) else report_mismatch("o_fault", o_fault, e.fault);
		assert (o_mem_read == e.mem_read)
			else report_mismatch("o_mem_read", o_mem_read, e.mem_read);
		assert (o_mem_write == e.mem_write)
			else report_mismatch("o_mem_write", o_mem_write, e.mem_write);
		if (e.check_rd) begin
			assert (o_rd == e.rd) else report_mismatch("o_rd", o_rd, e.rd);
		end
		if (e.jump) begin
			assert (o_jump_pc == e.jump_pc)
				else report_mismatch("o_jump_pc", o_jump_pc, e.jump_pc);
		end
		if (e.check_mem) begin
			assert (o_mem_address == e.mem_address)
				else report_mismatch("o_mem_address", o_mem_address, e.mem_address);
			assert (o_mem_width == e.mem_width)
				else report_mismatch("o_mem_width", o_mem_width, e.mem_width);
			assert (o_mem_signed == e.mem_signed)
				else report_mismatch("o_mem_signed", o_mem_signed, e.mem_signed);
		end
	endtask

	// Each o_valid pulse against the head of the queue
	always @(negedge i_clock) begin
		if (!i_reset) begin
			if (o_valid) begin
				if (expected.size() == 0) begin
					protocol_errors++;
					$display("An o_valid pulse came with no instruction outstanding at %0t", $time);
				end else begin
					compare_result(expected.pop_front());
				end
			end else if (expected.size() != 0 && expected[0].due_cycle < cycle) begin
				protocol_errors++;
				$display("No o_valid came for tag %0d by cycle %0d", expected[0].tag,
					expected[0].due_cycle);
				void'(expected.pop_front());
			end else if (expected.size() != 0 && expected[0].long_op &&
					cycle >= expected[0].accept_cycle) begin
				assert (o_busy) else begin
					protocol_errors++;
					$display("o_busy dropped while a multiply or divide was running at %0t", $time);
				end
			end
		end
	end

	assert property (@(posedge i_clock) i_memory_busy |-> o_busy) else begin
		protocol_errors++;
		$display("o_busy did not follow i_memory_busy at %0t", $time);
	end

	assert property (@(posedge i_clock) (!i_reset && i_memory_busy && i_decode_valid) |=> !o_valid)
		else begin
			protocol_errors++;
			$display("An instruction was accepted while the memory stage was busy at %0t", $time);
		end

	// Fault is sticky until reset
	assert property (@(posedge i_clock) (!i_reset && o_fault) |=> (o_fault || i_reset)) else begin
		protocol_errors++;
		$display("o_fault dropped without a reset at %0t", $time);
	end

	// ==============================
	initial begin
		i_reset = 1'b1;
		i_memory_busy = 1'b0;
		i_decode_valid = 1'b0;
		i_tag = '0;
		i_pc = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_imm = '0;
		i_rd_index = '0;
		i_class = CLASS_ARITH;
		i_alu_op = ALU_ADD;
		i_operand1_sel = SEL_ZERO;
		i_operand2_sel = SEL_ZERO;
		i_complex_op = OP_MUL;
		i_mem_width = '0;
		i_mem_signed = 1'b0;
		apply_reset();

		for (int i = 0; i < 42; i++) begin
			issue((i % 14 >= 8) ? CLASS_COMPARE : CLASS_ARITH, alu_op_t'(i % 14),
				operand_sel_t'(i % 5), operand_sel_t'((i / 5) % 5), OP_MUL,
				random_word(), random_word(), random_word());
		end
		for (int i = 0; i < 4; i++) begin
			issue(CLASS_JUMP, ALU_ADD, (i % 2 == 0) ? SEL_PC : SEL_RS1, SEL_IMM, OP_MUL,
				random_word(), random_word(), random_word());
		end
		for (int i = 0; i < 12; i++) begin
			i_rs1 = random_word();
			issue(CLASS_BRANCH, alu_op_t'(ALU_EQ + i % 6), SEL_RS1, SEL_RS2, OP_MUL, i_rs1,
				(i < 6) ? i_rs1 : random_word(), random_word());
		end

		for (int i = 0; i < 8; i++) begin
			issue((i % 2 == 0) ? CLASS_LOAD : CLASS_STORE, ALU_ADD, SEL_RS1, SEL_IMM, OP_MUL,
				random_word(), random_word(), random_word());
		end
		drain();
		stall_memory(6);
		issue(CLASS_LOAD, ALU_ADD, SEL_RS1, SEL_IMM, OP_MUL, random_word(), random_word(),
			random_word());

		for (int op = OP_MUL; op <= OP_REMU; op++) begin
			repeat (4) begin
				issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, complex_op_t'(op), random_word(),
					random_word(), 32'd0);
			end
		end
		for (int op = OP_DIV; op <= OP_REMU; op++) begin
			issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, complex_op_t'(op), random_word(),
				32'd0, 32'd0);
			issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, complex_op_t'(op), 32'h8000_0000,
				32'hffff_ffff, 32'd0);
		end

		// Each CSR access returns the old value
		for (int i = 0; i < 3; i++) begin
			issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRW, random_word(), 32'd0,
				csr_list[i]);
			issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRS, random_word(), 32'd0,
				csr_list[i]);
			issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRC, random_word(), 32'd0,
				csr_list[i]);
			issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRS, 32'd0, 32'd0, csr_list[i]);
		end
		issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRW, random_word(), 32'd0,
			`RV_CSR_MCYCLE);
		issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRS, 32'd0, 32'd0, `RV_CSR_MCYCLE);
		issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_MRET, 32'd0, 32'd0, 32'd0);
		issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_CSRRW, random_word(), 32'd0,
			`RV_CSR_MEPC);
		issue(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, OP_MRET, 32'd0, 32'd0, 32'd0);

		issue(CLASS_INVALID, ALU_ADD, SEL_RS1, SEL_RS2, OP_MUL, random_word(), random_word(),
			32'd0);
		drain();
		assert (o_fault) else report_mismatch("o_fault", o_fault, 1'b1);
		issue(CLASS_ARITH, ALU_XOR, SEL_RS1, SEL_RS2, OP_MUL, random_word(), random_word(),
			32'd0);
		issue(CLASS_ARITH, ALU_SUB, SEL_RS1, SEL_IMM, OP_MUL, random_word(), random_word(),
			32'd7);
		drain();
		assert (o_fault) else report_mismatch("o_fault", o_fault, 1'b1);
		apply_reset();
		assert (!o_fault) else report_mismatch("o_fault", o_fault, 1'b0);
		issue(CLASS_ARITH, ALU_ADD, SEL_RS1, SEL_RS2, OP_MUL, random_word(), random_word(),
			32'd0);
		drain();

		$display("Checks done: %0d value errors, %0d protocol errors", value_errors,
			protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
